// ==== filelist.f ====
common/exe_pkg.sv
exe/exe_alu.sv
exe/exe_branch_unit.sv
exe/exe_mul_unit.sv
exe/exe_ctrl.sv
exe/exe_stage_reg.sv
exe/exe_top.sv
dv/tb_clk_gen.sv
dv/tb_exe_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_exe_top -o sim_exe

./obj_dir/sim_exe | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED"
    exit 1
fi

// ==== dv/tb_exe_top.sv ====
`default_nettype none

module tb_exe_top;
    import exe_pkg::*;

    typedef struct packed {
        alu_op_e         op;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc_plus4;
        logic [XLEN-1:0] pred_pc;
        logic            pred_taken;
        logic            is_branch;
        logic            is_jalr;
        wb_src_e         wb_src;
        logic [4:0]      rd;
        logic [XLEN-1:0] exp_wb;
        logic            exp_redir;
        logic [XLEN-1:0] exp_pc;
        logic [7:0]      stall;       // stall cycles after the result
        logic [7:0]      flush_after; // busy cycles before a flush, 0 = none
    } row_t;

    logic      clk;
    logic      rst_n;
    id_ex_t    id_ex;
    logic      flush;
    logic      mem_stall;
    ex_mem_t   ex_mem;
    redirect_t redirect;
    logic      busy;

    row_t      rows[$];
    int        errors = 0;
    int        cycles = 0;
    int        cycle_limit = 0;
    int        seed;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n_o(rst_n));

    exe_top u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .id_ex_i     (id_ex),
        .flush_i     (flush),
        .mem_stall_i (mem_stall),
        .ex_mem_o    (ex_mem),
        .redirect_o  (redirect),
        .busy_o      (busy)
    );

    // ==============================
    // table building
    // ==============================
    task automatic add_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm,
                           input wb_src_e src, input logic [XLEN-1:0] exp,
                           input int stall, input int flush_after);
        row_t r;
        r = '0;
        r.op          = op;
        r.rs1         = a;
        r.rs2         = b;
        r.imm         = imm;
        r.pc_plus4    = 32'h400 + 32'(rows.size() * 4);
        r.wb_src      = src;
        r.rd          = 5'(rows.size() % 31 + 1); // never x0
        r.exp_wb      = exp;
        r.stall       = 8'(stall);
        r.flush_after = 8'(flush_after);
        rows.push_back(r);
    endtask

    task automatic add_ctl(input alu_op_e op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm,
                           input logic [XLEN-1:0] pc4, input logic [XLEN-1:0] pred,
                           input logic taken, input logic redir,
                           input logic [XLEN-1:0] redir_pc);
        row_t r;
        r = '0;
        r.op         = op;
        r.rs1        = a;
        r.rs2        = b;
        r.imm        = imm;
        r.pc_plus4   = pc4;
        r.pred_pc    = pred;
        r.pred_taken = taken;
        r.is_jalr    = (op == OP_JALR);
        r.is_branch  = (op != OP_JALR);
        r.wb_src     = r.is_jalr ? WB_PC4 : WB_ALU;
        r.rd         = r.is_jalr ? 5'd1 : 5'd0;
        r.exp_wb     = r.is_jalr ? pc4 : a + imm; // link value, or branch target
        r.exp_redir  = redir;
        r.exp_pc     = redir_pc;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        add_alu(OP_ADD, 32'h7fff_ffff, 32'h1, 32'h0, WB_ALU, 32'h8000_0000, 0, 0);
        add_alu(OP_SUB, 32'h5, 32'h7, 32'h0, WB_ALU, 32'hffff_fffe, 0, 0);
        add_alu(OP_AND, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h0, WB_ALU, 32'h00f0_1200, 0, 0);
        add_alu(OP_OR, 32'hf000_000f, 32'h0000_f0f0, 32'h0, WB_ALU, 32'hf000_f0ff, 0, 0);
        add_alu(OP_XOR, 32'haaaa_5555, 32'hffff_0000, 32'h0, WB_ALU, 32'h5555_5555, 3, 0);
        add_alu(OP_SLL, 32'h1, 32'h23, 32'h0, WB_ALU, 32'h8, 0, 0); // only shamt[4:0]
        add_alu(OP_SRL, 32'h8000_0000, 32'h4, 32'h0, WB_ALU, 32'h0800_0000, 0, 0);
        add_alu(OP_SRA, 32'h8000_0000, 32'h4, 32'h0, WB_ALU, 32'hf800_0000, 0, 0);
        add_alu(OP_SLT, 32'hffff_ffff, 32'h1, 32'h0, WB_ALU, 32'h1, 0, 0);
        add_alu(OP_SLTU, 32'hffff_ffff, 32'h1, 32'h0, WB_ALU, 32'h0, 0, 0);
        add_alu(OP_ADD, 32'h0, 32'h0, 32'h1234_5000, WB_IMM, 32'h1234_5000, 0, 0); // lui
        // predicted / actual: 1/1, 1/0, 0/1, 0/0
        add_ctl(OP_BEQ, 32'h1000, 32'h1000, 32'h20, 32'h204, 32'h1020, 1'b1, 1'b0, 32'h0);
        add_ctl(OP_BNE, 32'h1000, 32'h1000, 32'h20, 32'h208, 32'h1020, 1'b1, 1'b1, 32'h208);
        add_ctl(OP_BLT, 32'hffff_fff0, 32'h10, 32'h40, 32'h20c, 32'h0, 1'b0, 1'b1, 32'h30);
        add_ctl(OP_BLTU, 32'hffff_fff0, 32'h10, 32'h40, 32'h210, 32'h0, 1'b0, 1'b0, 32'h0);
        add_ctl(OP_BGE, 32'h10, 32'hffff_fff0, 32'h100, 32'h214, 32'h110, 1'b1, 1'b0, 32'h0);
        add_ctl(OP_BGEU, 32'h10, 32'hffff_fff0, 32'h100, 32'h218, 32'h110, 1'b1, 1'b1, 32'h218);
        add_ctl(OP_JALR, 32'h2001, 32'h0, 32'h10, 32'h21c, 32'h0, 1'b0, 1'b1, 32'h2010);
        add_ctl(OP_JALR, 32'h3003, 32'h0, 32'h4, 32'h220, 32'h3006, 1'b1, 1'b0, 32'h0);
        add_ctl(OP_JALR, 32'h3003, 32'h0, 32'h4, 32'h224, 32'h3008, 1'b1, 1'b1, 32'h3006);
        // random multiplies, third one gets flushed mid-run
        for (int i = 0; i < 6; i++) begin
            a = $random(seed);
            b = $random(seed);
            add_alu(OP_MUL, a, b, 32'h0, WB_ALU, a * b, (i == 4) ? 4 : 0, (i == 2) ? 6 : 0);
            if (i == 3)
                add_alu(OP_ADD, 32'h11, 32'h22, 32'h0, WB_ALU, 32'h33, 0, 0);
        end
        add_alu(OP_SUB, 32'h100, 32'h1, 32'h0, WB_ALU, 32'hff, 0, 0);
    endtask

    function automatic id_ex_t make_id_ex(input row_t r);
        id_ex_t d;
        d = '0;
        d.valid      = 1'b1;
        d.op         = r.op;
        d.rs1        = r.rs1;
        d.rs2        = r.rs2;
        d.imm        = r.imm;
        d.pc_plus4   = r.pc_plus4;
        d.pred_pc    = r.pred_pc;
        d.pred_taken = r.pred_taken;
        d.is_branch  = r.is_branch;
        d.is_jalr    = r.is_jalr;
        d.dmem_type  = r.rd[3:0]; // any pattern, carried through untouched
        d.reg_we     = !r.is_branch;
        d.rd         = r.rd;
        d.wb_src     = r.wb_src;
        d.illegal    = r.rd[4];
        return d;
    endfunction

    task automatic check_val(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
        assert (act === exp) else begin
            $display("Error %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    // ==============================
    // one row through the stage
    // ==============================
    task automatic run_row(input int idx, output bit ok);
        row_t      r;
        alu_op_e   op;
        ex_mem_t   held_mem;
        redirect_t held_red;
        id_ex_t    probe;
        int        busy_cycles;
        int        err_before;
        r           = rows[idx];
        op          = r.op;
        err_before  = errors;
        busy_cycles = 0;
        @(posedge clk);
        id_ex <= make_id_ex(r);
        @(negedge clk);
        while (busy && (r.flush_after == 0 || busy_cycles < r.flush_after)) begin
            busy_cycles++;
            @(negedge clk);
        end
        if (r.flush_after != 0) begin
            probe = make_id_ex(rows[17]); // mispredicting jalr, must not be taken
            @(posedge clk);
            flush <= 1'b1;
            id_ex <= probe;
            @(posedge clk);
            flush       <= 1'b0;
            id_ex.valid <= 1'b0; // decode is flushed too
            @(negedge clk);
            check_val("ex_mem_o.valid", 1'b0, ex_mem.valid);
            check_val("ex_mem_o.reg_we", 1'b0, ex_mem.reg_we);
            check_val("redirect_o.valid", 1'b0, redirect.valid);
            check_val("busy_o", 1'b0, busy);
        end else begin
            if (op == OP_MUL) begin
                assert (busy_cycles >= MUL_STEPS) else begin
                    $display("busy_o fell after %0d cycles, before the product", busy_cycles);
                    errors++;
                end
            end else begin
                assert (busy_cycles == 0) else begin
                    $display("busy_o was high for a single-cycle instruction");
                    errors++;
                end
            end
            @(posedge clk); // result loads here
            id_ex.valid <= 1'b0;
            mem_stall   <= (r.stall != 0);
            @(negedge clk);
            check_val("ex_mem_o.valid", 1'b1, ex_mem.valid);
            check_val("ex_mem_o.wb_value", r.exp_wb, ex_mem.wb_value);
            check_val("ex_mem_o.rd", r.rd, ex_mem.rd);
            check_val("ex_mem_o.reg_we", !r.is_branch, ex_mem.reg_we);
            check_val("ex_mem_o.store_data", r.rs2, ex_mem.store_data);
            check_val("ex_mem_o.dmem_type", r.rd[3:0], ex_mem.dmem_type);
            check_val("ex_mem_o.illegal", r.rd[4], ex_mem.illegal);
            check_val("redirect_o.valid", r.exp_redir, redirect.valid);
            if (r.exp_redir)
                check_val("redirect_o.pc", r.exp_pc, redirect.pc);
            if (r.stall != 0) begin
                held_mem = ex_mem;
                held_red = redirect;
                probe    = make_id_ex(rows[0]); // offered but must not be taken
                @(posedge clk);
                id_ex <= probe;
                repeat (r.stall) begin
                    @(negedge clk);
                    assert (ex_mem === held_mem && redirect === held_red) else begin
                        $display("stage output changed while mem_stall_i was high");
                        errors++;
                    end
                end
                @(posedge clk);
                mem_stall   <= 1'b0;
                id_ex.valid <= 1'b0;
            end
        end
        ok = (errors == err_before);
        $display("row %0d %s %s", idx, op.name(), ok ? "ok" : "FAILED");
    endtask

    // ==============================
    // watchdog
    // ==============================
    always @(posedge clk) begin
        if (rst_n) begin
            cycles <= cycles + 1;
            if (cycle_limit > 0 && cycles >= cycle_limit) begin
                $display("timeout, the run did not finish within %0d cycles", cycle_limit);
                $display("Test failed");
                $finish;
            end
        end
    end

    initial begin
        int  n_pass;
        int  n_fail;
        bit  ok;
        id_ex     <= '0;
        flush     <= 1'b0;
        mem_stall <= 1'b0;
        n_pass    = 0;
        n_fail    = 0;
        seed      = 32'h4564_02d2;
        build_table();
        cycle_limit = rows.size() * (MUL_STEPS + 10);
        wait (rst_n === 1'b1);
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i, ok);
            if (ok)
                n_pass++;
            else
                n_fail++;
        end
        $display("rows passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n_o
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // period 8
    end

    // sync reset, low for the first 4 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== exe/exe_top.sv ====
`default_nettype none

module exe_top (
    input  logic               clk,
    input  logic               rst_n_i,
    input  exe_pkg::id_ex_t    id_ex_i,
    input  logic               flush_i,
    input  logic               mem_stall_i,
    output exe_pkg::ex_mem_t   ex_mem_o,
    output exe_pkg::redirect_t redirect_o,
    output logic               busy_o
);
    import exe_pkg::*;

    logic            mul_start;
    logic            mul_done;
    logic            load_en;
    logic            clear;
    logic [XLEN-1:0] mul_result;
    logic [XLEN-1:0] alu_result;
    logic            cond_true;
    redirect_t       redirect_next;

    // ==============================
    // control
    // ==============================
    exe_ctrl u_ctrl (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .id_valid_i  (id_ex_i.valid),
        .op_i        (id_ex_i.op),
        .flush_i     (flush_i),
        .mem_stall_i (mem_stall_i),
        .mul_done_i  (mul_done),
        .mul_start_o (mul_start),
        .load_en_o   (load_en),
        .clear_o     (clear),
        .busy_o      (busy_o)
    );

    // ==============================
    // datapath
    // ==============================
    exe_alu u_alu (
        .op_i        (id_ex_i.op),
        .a_i         (id_ex_i.rs1),
        .b_i         (id_ex_i.rs2),
        .imm_i       (id_ex_i.imm),
        .result_o    (alu_result),
        .cond_true_o (cond_true)
    );

    exe_branch_unit u_branch (
        .id_ex_i      (id_ex_i),
        .alu_result_i (alu_result),
        .cond_true_i  (cond_true),
        .redirect_o   (redirect_next)
    );

    exe_mul_unit u_mul (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .start_i  (mul_start),
        .a_i      (id_ex_i.rs1),
        .b_i      (id_ex_i.rs2),
        .done_o   (mul_done),
        .result_o (mul_result)
    );

    exe_stage_reg u_stage_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .load_en_i    (load_en),
        .clear_i      (clear),
        .id_ex_i      (id_ex_i),
        .alu_result_i (alu_result),
        .mul_result_i (mul_result),
        .redirect_i   (redirect_next),
        .ex_mem_o     (ex_mem_o),
        .redirect_o   (redirect_o)
    );

endmodule

`default_nettype wire

// ==== exe/exe_stage_reg.sv ====
`default_nettype none

module exe_stage_reg (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     load_en_i,
    input  logic                     clear_i,
    input  exe_pkg::id_ex_t          id_ex_i,
    input  logic [exe_pkg::XLEN-1:0] alu_result_i,
    input  logic [exe_pkg::XLEN-1:0] mul_result_i,
    input  exe_pkg::redirect_t       redirect_i,
    output exe_pkg::ex_mem_t         ex_mem_o,
    output exe_pkg::redirect_t       redirect_o
);
    import exe_pkg::*;

    ex_mem_t         ex_mem_q;
    redirect_t       redirect_q;
    logic [XLEN-1:0] exe_value; // alu or mul
    logic [XLEN-1:0] wb_value;

    assign exe_value = (id_ex_i.op == OP_MUL) ? mul_result_i : alu_result_i;

    // ==============================
    // write-back select
    // ==============================
    always_comb begin
        case (id_ex_i.wb_src)
            WB_IMM:  wb_value = id_ex_i.imm;      // lui
            WB_PC4:  wb_value = id_ex_i.pc_plus4; // link address
            default: wb_value = exe_value;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || clear_i) begin
            ex_mem_q.valid   <= 1'b0;
            ex_mem_q.reg_we  <= 1'b0;
            redirect_q.valid <= 1'b0;
        end else if (load_en_i) begin
            ex_mem_q.valid      <= id_ex_i.valid;
            ex_mem_q.reg_we     <= id_ex_i.valid && id_ex_i.reg_we; // bubbles never write
            ex_mem_q.wb_value   <= wb_value;
            ex_mem_q.store_data <= id_ex_i.rs2;
            ex_mem_q.dmem_type  <= id_ex_i.dmem_type;
            ex_mem_q.rd         <= id_ex_i.rd;
            ex_mem_q.illegal    <= id_ex_i.illegal;
            redirect_q          <= redirect_i; // same edge as the result
        end
        // else hold under mem stall or while mul runs
    end

    assign ex_mem_o   = ex_mem_q;
    assign redirect_o = redirect_q;

endmodule

`default_nettype wire

// ==== exe/exe_ctrl.sv ====
`default_nettype none

module exe_ctrl (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             id_valid_i,
    input  exe_pkg::alu_op_e op_i,
    input  logic             flush_i,
    input  logic             mem_stall_i,
    input  logic             mul_done_i,
    output logic             mul_start_o,
    output logic             load_en_o, // stage reg load
    output logic             clear_o,   // kill stage reg valids
    output logic             busy_o     // decode holds id_ex
);
    import exe_pkg::*;

    exe_state_e state_q;
    exe_state_e state_d;
    logic       mul_req;
    logic       pending_q; // a run still going, e.g. left behind by a flush

    assign mul_req = id_valid_i && (op_i == OP_MUL);

    // ==============================
    // next state and strobes
    // ==============================
    always_comb begin
        state_d     = state_q;
        mul_start_o = 1'b0;
        load_en_o   = 1'b0;
        clear_o     = flush_i; // flush wins everywhere
        if (flush_i) begin
            state_d = ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (mul_req) begin
                        if (!mem_stall_i && !pending_q) begin
                            mul_start_o = 1'b1;
                            state_d     = ST_MUL;
                        end
                    end else if (!mem_stall_i) begin
                        load_en_o = 1'b1; // single-cycle op or bubble
                    end
                end
                ST_MUL: begin
                    if (mul_done_i) begin
                        if (mem_stall_i) begin
                            state_d = ST_DONE; // park the product
                        end else begin
                            load_en_o = 1'b1;
                            state_d   = ST_IDLE;
                        end
                    end
                end
                ST_DONE: begin
                    if (!mem_stall_i) begin
                        load_en_o = 1'b1;
                        state_d   = ST_IDLE;
                    end
                end
                default: state_d = ST_IDLE;
            endcase
        end
    end

    // low again in the cycle the result is loaded
    assign busy_o = (state_q != ST_IDLE || mul_req) && !load_en_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            pending_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (mul_start_o)
                pending_q <= 1'b1;
            else if (mul_done_i)
                pending_q <= 1'b0; // also drains a flushed run
        end
    end

    // every start comes back as one done pulse, MUL_STEPS+1 edges later
    a_mul_latency: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        mul_start_o |-> ##(MUL_STEPS + 1) mul_done_i
    );

    // a product only returns for a run started here
    a_done_needs_run: assert property (
        @(posedge clk) disable iff (!rst_n_i) mul_done_i |-> pending_q
    );

endmodule

`default_nettype wire

// ==== exe/exe_mul_unit.sv ====
`default_nettype none

module exe_mul_unit (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     start_i, // one-cycle pulse from ctrl
    input  logic [exe_pkg::XLEN-1:0] a_i,
    input  logic [exe_pkg::XLEN-1:0] b_i,
    output logic                     done_o,
    output logic [exe_pkg::XLEN-1:0] result_o // low half of a*b
);
    import exe_pkg::*;

    logic [XLEN-1:0]      mcand_q; // shifts left
    logic [XLEN-1:0]      mplier_q; // shifts right
    logic [XLEN-1:0]      acc_q;
    logic [MUL_CNT_W-1:0] cnt_q;
    logic                 busy_q;
    logic                 done_q;
    logic                 last_step;

    assign last_step = busy_q && (cnt_q == MUL_CNT_W'(MUL_STEPS - 1));

    // ==============================
    // control bits
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= last_step; // pulse right after final step
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (last_step)
                    busy_q <= 1'b0;
            end
        end
    end

    // datapath, no reset needed
    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand_q  <= a_i;
            mplier_q <= b_i;
            acc_q    <= '0;
        end else if (busy_q) begin
            if (mplier_q[0])
                acc_q <= acc_q + mcand_q; // wraps, only low bits kept
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign done_o   = done_q;
    assign result_o = acc_q;

    // ctrl must wait out a running multiply before the next start
    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n_i) start_i |-> !busy_q
    );

endmodule

`default_nettype wire

// ==== exe/exe_branch_unit.sv ====
`default_nettype none

module exe_branch_unit (
    input  exe_pkg::id_ex_t           id_ex_i,
    input  logic [exe_pkg::XLEN-1:0] alu_result_i, // branch / jalr target
    input  logic                     cond_true_i,  // actual outcome
    output exe_pkg::redirect_t        redirect_o
);
    import exe_pkg::*;

    logic            mispredict;
    logic [XLEN-1:0] correct_pc;
    logic            jalr_hit;

    // predictor already pointed at the right jalr target
    assign jalr_hit = id_ex_i.pred_taken && (id_ex_i.pred_pc == alu_result_i);

    // ==============================
    // outcome vs prediction
    // ==============================
    always_comb begin
        mispredict = 1'b0;
        correct_pc = id_ex_i.pc_plus4;
        if (id_ex_i.is_branch) begin
            mispredict = cond_true_i ^ id_ex_i.pred_taken;
            // taken -> target, not taken -> fall through
            correct_pc = cond_true_i ? alu_result_i : id_ex_i.pc_plus4;
        end else if (id_ex_i.is_jalr) begin
            mispredict = !jalr_hit;
            correct_pc = alu_result_i;
        end
    end

    // bubbles never redirect
    assign redirect_o.valid = id_ex_i.valid && mispredict;
    assign redirect_o.pc    = correct_pc;

endmodule

`default_nettype wire

// ==== exe/exe_alu.sv ====
`default_nettype none

module exe_alu (
    input  exe_pkg::alu_op_e          op_i,
    input  logic [exe_pkg::XLEN-1:0] a_i,   // rs1
    input  logic [exe_pkg::XLEN-1:0] b_i,   // rs2
    input  logic [exe_pkg::XLEN-1:0] imm_i, // offset for branch and jalr targets
    output logic [exe_pkg::XLEN-1:0] result_o,
    output logic                     cond_true_o
);
    import exe_pkg::*;

    logic [XLEN-1:0] sum;      // rs1 + imm, shared by all target ops
    logic [4:0]      shamt;
    logic            lt_s;
    logic            lt_u;
    logic            eq;

    assign sum   = a_i + imm_i;
    assign shamt = b_i[4:0];  // rv32 uses low 5 bits only
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;
    assign eq    = a_i == b_i;

    // ==============================
    // result mux
    // ==============================
    always_comb begin
        result_o    = '0;
        cond_true_o = 1'b0;
        case (op_i)
            OP_ADD:  result_o = a_i + b_i;
            OP_SUB:  result_o = a_i - b_i;
            OP_AND:  result_o = a_i & b_i;
            OP_OR:   result_o = a_i | b_i;
            OP_XOR:  result_o = a_i ^ b_i;
            OP_SLL:  result_o = a_i << shamt;
            OP_SRL:  result_o = a_i >> shamt;
            OP_SRA:  result_o = XLEN'($signed(a_i) >>> shamt); // sign fill
            OP_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
            // branches, target on result, outcome on cond
            OP_BEQ:  begin result_o = sum; cond_true_o = eq;    end
            OP_BNE:  begin result_o = sum; cond_true_o = !eq;   end
            OP_BLT:  begin result_o = sum; cond_true_o = lt_s;  end
            OP_BGE:  begin result_o = sum; cond_true_o = !lt_s; end
            OP_BLTU: begin result_o = sum; cond_true_o = lt_u;  end
            OP_BGEU: begin result_o = sum; cond_true_o = !lt_u; end
            OP_JALR: begin
                result_o    = {sum[XLEN-1:1], 1'b0}; // lsb cleared per spec
                cond_true_o = 1'b1;                  // always taken
            end
            default: result_o = '0; // OP_MUL comes from the mul unit
        endcase
    end

endmodule

`default_nettype wire

// ==== common/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int DMEM_W    = 4;  // load/store type code
    localparam int MUL_STEPS = 32; // one step per multiplier bit
    localparam int MUL_CNT_W = $clog2(MUL_STEPS);

    // ==============================
    // opcodes and states
    // ==============================
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JALR,
        OP_MUL
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU, // alu or mul result
        WB_IMM, // lui
        WB_PC4  // jal / jalr link value
    } wb_src_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MUL,  // multiplier running
        ST_DONE  // product ready, mem stage stalled
    } exe_state_e;

    // ==============================
    // stage bundles
    // ==============================
    typedef struct packed {
        logic                 valid;
        alu_op_e              op;
        logic [XLEN-1:0]      rs1;
        logic [XLEN-1:0]      rs2;
        logic [XLEN-1:0]      imm;
        logic [XLEN-1:0]      pc_plus4;
        logic [XLEN-1:0]      pred_pc;    // static predictor target
        logic                 pred_taken;
        logic                 is_branch;
        logic                 is_jalr;
        logic [DMEM_W-1:0]    dmem_type;
        logic                 reg_we;
        logic [REG_IDX_W-1:0] rd;
        wb_src_e              wb_src;
        logic                 illegal;
    } id_ex_t;

    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      wb_value;
        logic [XLEN-1:0]      store_data; // rs2 for stores
        logic [DMEM_W-1:0]    dmem_type;
        logic                 reg_we;
        logic [REG_IDX_W-1:0] rd;
        logic                 illegal;
    } ex_mem_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

endpackage

`default_nettype wire
